/* build.f */
+incdir+design
design/poolPkg.sv
design/actStream_if.sv
design/startDebounce.sv
design/frameReceiver.sv
design/maxPoolCore.sv
design/streamTransmitter.sv
design/poolTop.sv
dv/poolTb.sv

/* design/actStream_if.sv */
// Valid/ready stream of one activation word per beat; source holds dat and last until rdy
interface actStream_if;

    poolPkg::actWord_u dat;
    logic              vld;
    logic              last;
    logic              rdy;

    // Producer side
    modport src (
        output dat,
        output vld,
        output last,
        input  rdy
    );

    // Consumer side
    modport snk (
        input  dat,
        input  vld,
        input  last,
        output rdy
    );

endinterface

/* design/frameReceiver.sv */
// Inbound side; first beat after start is the header, input outside a frame is not accepted
`include "poolSettings.svh"

module frameReceiver (
    input  logic              clk,
    input  logic              reset,
    input  logic              startPulse,
    input  poolPkg::actWord_u inDat,
    input  logic              inDatVld,
    output logic              inDatRdy,
    actStream_if.src          out,
    output poolPkg::poolCfg_s cfg
);

    localparam int CNT_W = `POOL_K_WIDTH + `POOL_NUMOUT_WIDTH;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_HEADER = 2'd1;
    localparam logic [1:0] ST_DATA   = 2'd2;

    logic [1:0]        state;
    logic [CNT_W-1:0]  wordsLeft;
    logic [CNT_W-1:0]  frameWords;
    poolPkg::actWord_u holdDat;
    logic              holdVld;
    logic              inAccept;
    logic              dataAccept;

    // Total data beats announced by the header
    assign frameWords = CNT_W'(inDat.hdr.kSize) * CNT_W'(inDat.hdr.numOut);

    always_comb begin
        case (state)
            ST_HEADER: inDatRdy = 1'b1;
            ST_DATA:   inDatRdy = ~holdVld | out.rdy;
            default:   inDatRdy = 1'b0;
        endcase
    end

    assign inAccept   = inDatVld & inDatRdy;
    assign dataAccept = inAccept & (state == ST_DATA);

    // ============================================================
    // Frame FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            wordsLeft <= '0;
            cfg       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (startPulse) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (inAccept) begin
                        cfg.kSize  <= inDat.hdr.kSize;
                        cfg.numOut <= inDat.hdr.numOut;
                        wordsLeft  <= frameWords;
                        state      <= (frameWords == '0) ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (inAccept) begin
                        wordsLeft <= wordsLeft - 1'b1;
                        if (wordsLeft == CNT_W'(1)) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One-entry holding register toward the core
    always_ff @(posedge clk) begin
        if (reset) begin
            holdVld <= 1'b0;
        end else if (dataAccept) begin
            holdVld <= 1'b1;
        end else if (out.rdy) begin
            holdVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dataAccept) begin
            holdDat <= inDat;
        end
    end

    assign out.dat  = holdDat;
    assign out.vld  = holdVld;
    assign out.last = 1'b0;

    // A zero group size would never close a group in the core
    hdrKNonZero: assert property (@(posedge clk) disable iff (reset)
        (state == ST_HEADER && inAccept) |-> (inDat.hdr.kSize != '0))
        else $error("header with zero group size accepted");

endmodule

/* design/maxPoolCore.sv */
// Per-lane unsigned max over K words; cfg must not change while a frame is in flight
`include "poolSettings.svh"

module maxPoolCore (
    input  logic              clk,
    input  logic              reset,
    input  poolPkg::poolCfg_s cfg,
    actStream_if.snk          in,
    actStream_if.src          out
);

    logic [`POOL_K_WIDTH-1:0]                     grpCnt;
    logic [`POOL_NUMOUT_WIDTH-1:0]                outCnt;
    logic [`POOL_LANES-1:0][`POOL_LANE_WIDTH-1:0] maxAcc;
    logic [`POOL_LANES-1:0][`POOL_LANE_WIDTH-1:0] maxNext;
    poolPkg::actWord_u                            resDat;
    logic                                         resVld;
    logic                                         resLast;
    logic                                         groupEnd;
    logic                                         lastGroup;
    logic                                         inAccept;

    assign groupEnd  = (grpCnt == cfg.kSize - 1'b1);
    assign lastGroup = (outCnt == cfg.numOut - 1'b1);

    // Stall only when a finished group has nowhere to go
    assign in.rdy   = ~groupEnd | ~resVld | out.rdy;
    assign inAccept = in.vld & in.rdy;

    // First word of a group loads directly
    always_comb begin
        for (int i = 0; i < `POOL_LANES; i++) begin
            if (grpCnt == '0 || in.dat.lane[i] > maxAcc[i]) begin
                maxNext[i] = in.dat.lane[i];
            end else begin
                maxNext[i] = maxAcc[i];
            end
        end
    end

    // ============================================================
    // Group and output counters
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            grpCnt <= '0;
            outCnt <= '0;
        end else if (inAccept) begin
            if (groupEnd) begin
                grpCnt <= '0;
                outCnt <= lastGroup ? '0 : outCnt + 1'b1;
            end else begin
                grpCnt <= grpCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resVld  <= 1'b0;
            resLast <= 1'b0;
        end else if (inAccept && groupEnd) begin
            resVld  <= 1'b1;
            resLast <= lastGroup;
        end else if (out.rdy) begin
            resVld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inAccept) begin
            maxAcc <= maxNext;
        end
        if (inAccept && groupEnd) begin
            resDat.lane <= maxNext;
        end
    end

    assign out.dat  = resDat;
    assign out.vld  = resVld;
    assign out.last = resLast;

    // Pending result survives transmitter back-pressure untouched
    resHeld: assert property (@(posedge clk) disable iff (reset)
        (resVld && !out.rdy) |=> (resVld && $stable(resDat)))
        else $error("pooled result overwritten before transfer");

endmodule

/* design/poolPkg.sv */
// Stream word views and pooling config; field widths assume the values of the settings header
`include "poolSettings.svh"

package poolPkg;

    // Header word layout with kSize in the lowest bits
    typedef struct packed {
        logic [`POOL_WORD_WIDTH-`POOL_NUMOUT_WIDTH-`POOL_K_WIDTH-1:0] reserved;
        logic [`POOL_NUMOUT_WIDTH-1:0]                                numOut;
        logic [`POOL_K_WIDTH-1:0]                                     kSize;
    } frameHeader_s;

    // One stream word with a header view and a lane view
    typedef union packed {
        frameHeader_s                                   hdr;
        logic [`POOL_LANES-1:0][`POOL_LANE_WIDTH-1:0]   lane;
    } actWord_u;

    // Decoded frame config held by the receiver
    typedef struct packed {
        logic [`POOL_K_WIDTH-1:0]      kSize;
        logic [`POOL_NUMOUT_WIDTH-1:0] numOut;
    } poolCfg_s;

endpackage

/* design/poolSettings.svh */
// Shared sizes for the pooling datapath; K must stay in 1..15 and lanes times width sets the port
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

// Activation lanes packed into one stream word
`define POOL_LANES 8

// Unsigned bits per lane
`define POOL_LANE_WIDTH 8

// Stream word width seen on the ports
`define POOL_WORD_WIDTH (`POOL_LANES * `POOL_LANE_WIDTH)

// Header field widths with the group size in the low bits
`define POOL_K_WIDTH 4
`define POOL_NUMOUT_WIDTH 16

// Stable cycles before the start button level is trusted
`define POOL_DEB_CYCLES 4

`endif

/* design/poolTop.sv */
// Pooling accelerator top; one frame per start press, outDat is only meaningful with outDatVld
`include "poolSettings.svh"

module poolTop (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        startBtn,
    input  logic [`POOL_WORD_WIDTH-1:0] inDat,
    input  logic                        inDatVld,
    output logic                        inDatRdy,
    output logic [`POOL_WORD_WIDTH-1:0] outDat,
    output logic                        outDatVld,
    output logic                        outDatLast,
    input  logic                        outDatRdy,
    output logic                        netFnh
);

    logic              startPulse;
    poolPkg::actWord_u inWord;
    poolPkg::actWord_u outWord;
    poolPkg::poolCfg_s cfg;

    actStream_if rxToPool ();
    actStream_if poolToTx ();

    // Pad vectors to stream words
    assign inWord = inDat;
    assign outDat = outWord;

    // ============================================================
    // Start button
    // ============================================================
    startDebounce uStartDebounce (
        .clk        (clk),
        .reset      (reset),
        .startBtn   (startBtn),
        .startPulse (startPulse)
    );

    // ============================================================
    // Datapath
    // ============================================================
    frameReceiver uFrameReceiver (
        .clk        (clk),
        .reset      (reset),
        .startPulse (startPulse),
        .inDat      (inWord),
        .inDatVld   (inDatVld),
        .inDatRdy   (inDatRdy),
        .out        (rxToPool.src),
        .cfg        (cfg)
    );

    maxPoolCore uMaxPoolCore (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .in    (rxToPool.snk),
        .out   (poolToTx.src)
    );

    streamTransmitter uStreamTransmitter (
        .clk        (clk),
        .reset      (reset),
        .startPulse (startPulse),
        .in         (poolToTx.snk),
        .outDat     (outWord),
        .outDatVld  (outDatVld),
        .outDatLast (outDatLast),
        .outDatRdy  (outDatRdy),
        .netFnh     (netFnh)
    );

endmodule

/* design/startDebounce.sv */
// Start pulse on the debounced falling edge; the button must hold still for POOL_DEB_CYCLES cycles
`include "poolSettings.svh"

module startDebounce (
    input  logic clk,
    input  logic reset,
    input  logic startBtn,
    output logic startPulse
);

    localparam int CNT_W = $clog2(`POOL_DEB_CYCLES + 1);

    logic             debLevel;
    logic             debLevelDly;
    logic [CNT_W-1:0] stableCnt;

    // Count cycles the raw button disagrees with the trusted level
    always_ff @(posedge clk) begin
        if (reset) begin
            debLevel  <= 1'b0;
            stableCnt <= '0;
        end else if (startBtn != debLevel) begin
            if (stableCnt == CNT_W'(`POOL_DEB_CYCLES - 1)) begin
                debLevel  <= startBtn;
                stableCnt <= '0;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end else begin
            stableCnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            debLevelDly <= 1'b0;
        end else begin
            debLevelDly <= debLevel;
        end
    end

    // Release of the button starts the frame
    assign startPulse = debLevelDly & ~debLevel;

endmodule

/* design/streamTransmitter.sv */
// Outbound side with a two-entry queue; netFnh stays set until the next start pulse
module streamTransmitter (
    input  logic              clk,
    input  logic              reset,
    input  logic              startPulse,
    actStream_if.snk          in,
    output poolPkg::actWord_u outDat,
    output logic              outDatVld,
    output logic              outDatLast,
    input  logic              outDatRdy,
    output logic              netFnh
);

    poolPkg::actWord_u qDat [2];
    logic [1:0]        qLast;
    logic              wrPtr;
    logic              rdPtr;
    logic [1:0]        count;
    logic              push;
    logic              pop;

    assign in.rdy = (count != 2'd2);
    assign push   = in.vld & in.rdy;

    assign outDatVld  = (count != 2'd0);
    assign outDat     = qDat[rdPtr];
    assign outDatLast = outDatVld & qLast[rdPtr];
    assign pop        = outDatVld & outDatRdy;

    // Queue pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wrPtr <= ~wrPtr;
            end
            if (pop) begin
                rdPtr <= ~rdPtr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            qDat[wrPtr]  <= in.dat;
            qLast[wrPtr] <= in.last;
        end
    end

    // Network done once the tagged word has left
    always_ff @(posedge clk) begin
        if (reset) begin
            netFnh <= 1'b0;
        end else if (startPulse) begin
            netFnh <= 1'b0;
        end else if (pop && qLast[rdPtr]) begin
            netFnh <= 1'b1;
        end
    end

    // A beat taken while full would overwrite the waiting head entry
    qNoOverflow: assert property (@(posedge clk) disable iff (reset)
        (outDatVld && !outDatRdy) |=>
            (outDatVld && $stable(outDat) && $stable(outDatLast)))
        else $error("output queue head changed under back-pressure");

endmodule

/* dv/poolTb.sv */
// Random pooling frames checked against a queue model; seed 94, checks need simulator assertions on
`include "poolSettings.svh"

module poolTb;

    localparam int W  = `POOL_WORD_WIDTH;
    localparam int LW = `POOL_LANE_WIDTH;

    // Worst case frame is K 15 times 12 outputs plus header and results
    localparam int NUM_FRAMES      = 15;
    localparam int MAX_FRAME_WORDS = 15 * 12 + 1 + 12;
    localparam int START_WAIT      = 3 * `POOL_DEB_CYCLES + 8;
    localparam int IDLE_CYCLES     = 100;
    localparam int TIMEOUT_CYCLES  = NUM_FRAMES * MAX_FRAME_WORDS * 20
                                   + NUM_FRAMES * (START_WAIT + `POOL_DEB_CYCLES + 4)
                                   + 16 + IDLE_CYCLES;

    logic         clk = 1'b0;
    logic         reset;
    logic         startBtn;
    logic [W-1:0] inDat;
    logic         inDatVld;
    logic         inDatRdy;
    logic [W-1:0] outDat;
    logic         outDatVld;
    logic         outDatLast;
    logic         outDatRdy;
    logic         netFnh;

    int errCnt   = 0;
    int checkCnt = 0;
    int testCnt  = 0;
    int testFail = 0;
    int cycleCnt = 0;

    poolTop DUT (
        .clk        (clk),
        .reset      (reset),
        .startBtn   (startBtn),
        .inDat      (inDat),
        .inDatVld   (inDatVld),
        .inDatRdy   (inDatRdy),
        .outDat     (outDat),
        .outDatVld  (outDatVld),
        .outDatLast (outDatLast),
        .outDatRdy  (outDatRdy),
        .netFnh     (netFnh)
    );

    always #50 clk = ~clk;

    // Watchdog on total run length
    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkThat(input bit cond, input string what);
        checkCnt++;
        assert (cond) else begin
            errCnt++;
            $display("Error at time %0t: %s", $time, what);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCnt++;
        if (errCnt == errBefore) begin
            $display("Test %s: passed", name);
        end else begin
            testFail++;
            $display("Test %s: FAILED with %0d errors", name, errCnt - errBefore);
        end
    endtask

    // Full press and release, then wait for the receiver to open
    task automatic pressStart(output bit started);
        started  = 1'b0;
        startBtn = 1'b1;
        repeat (`POOL_DEB_CYCLES + 2) @(negedge clk);
        startBtn = 1'b0;
        for (int i = 0; i < START_WAIT && !started; i++) begin
            @(negedge clk);
            if (inDatRdy) begin
                started = 1'b1;
            end
        end
        checkThat(started, "inDatRdy never rose after a full button press");
    endtask

    // ============================================================
    // One frame with its own model
    // ============================================================
    task automatic runFrame(input int k, input int numOut, input bit stall);
        logic [W-1:0] inQ[$];
        logic [W-1:0] expQ[$];
        logic [W-1:0] word;
        logic [W-1:0] maxWord;
        bit           started;

        word = '0;
        word[`POOL_K_WIDTH-1:0] = k[`POOL_K_WIDTH-1:0];
        word[`POOL_K_WIDTH +: `POOL_NUMOUT_WIDTH] = numOut[`POOL_NUMOUT_WIDTH-1:0];
        inQ.push_back(word);
        for (int g = 0; g < numOut; g++) begin
            maxWord = '0;
            for (int j = 0; j < k; j++) begin
                word = {$urandom, $urandom};
                inQ.push_back(word);
                for (int l = 0; l < `POOL_LANES; l++) begin
                    if (word[l*LW +: LW] > maxWord[l*LW +: LW]) begin
                        maxWord[l*LW +: LW] = word[l*LW +: LW];
                    end
                end
            end
            expQ.push_back(maxWord);
        end

        pressStart(started);
        checkThat(!netFnh, "netFnh still set after a new start");
        if (started) begin
            while (expQ.size() > 0) begin
                @(negedge clk);
                outDatRdy = stall ? ($urandom_range(99) >= 50) : 1'b1;
                // Valid only drops once the beat has gone
                if (inQ.size() == 0) begin
                    inDatVld = 1'b0;
                end else if (!inDatVld) begin
                    inDatVld = !stall || ($urandom_range(99) < 70);
                end
                inDat = (inQ.size() > 0) ? inQ[0] : '0;
                if (inDatVld && inDatRdy) begin
                    void'(inQ.pop_front());
                end
                if (outDatVld && outDatRdy) begin
                    checkThat(outDat == expQ[0],
                        $sformatf("outDat %h, expected %h", outDat, expQ[0]));
                    checkThat(outDatLast == (expQ.size() == 1),
                        $sformatf("outDatLast %b with %0d words left", outDatLast, expQ.size()));
                    void'(expQ.pop_front());
                end
            end
            @(negedge clk);
            inDatVld  = 1'b0;
            outDatRdy = 1'b1;
            checkThat(inQ.size() == 0, "input words left over after the last output");
            checkThat(!outDatVld, "extra output word after the last-tagged beat");
            checkThat(netFnh, "netFnh did not rise after the last-tagged beat");
        end
    endtask

    initial begin
        int errBefore;

        reset     = 1'b1;
        startBtn  = 1'b0;
        inDat     = '0;
        inDatVld  = 1'b0;
        outDatRdy = 1'b0;
        void'($urandom(94));
        repeat (16) @(negedge clk);
        reset     = 1'b0;
        outDatRdy = 1'b1;

        errBefore = errCnt;
        repeat (40) begin
            @(negedge clk);
            checkThat(!netFnh && !outDatVld && !outDatLast && !inDatRdy,
                "outputs active while idle");
        end
        reportTest("1 idle after reset", errBefore);

        // Short press must be filtered
        errBefore = errCnt;
        startBtn = 1'b1;
        repeat (`POOL_DEB_CYCLES - 1) @(negedge clk);
        startBtn = 1'b0;
        repeat (3 * `POOL_DEB_CYCLES + 4) begin
            @(negedge clk);
            checkThat(!inDatRdy, "short button pulse started a frame");
        end
        runFrame(2, 3, 1'b0);
        reportTest("2 debounce", errBefore);

        errBefore = errCnt;
        runFrame(1, 8, 1'b0);
        reportTest("3 K equal to 1", errBefore);

        errBefore = errCnt;
        repeat (6) begin
            runFrame($urandom_range(15, 1), $urandom_range(12, 1), 1'b0);
        end
        reportTest("4 random frames", errBefore);

        errBefore = errCnt;
        repeat (6) begin
            runFrame($urandom_range(15, 1), $urandom_range(12, 1), 1'b1);
        end
        reportTest("5 back-pressure", errBefore);

        // Flag holds through idle, clears on the next start
        errBefore = errCnt;
        repeat (20) begin
            @(negedge clk);
            checkThat(netFnh, "netFnh dropped while idle");
        end
        runFrame(3, 4, 1'b0);
        reportTest("6 network finished flag", errBefore);

        $display("Tests: %0d run, %0d failed; checks: %0d run, %0d failed",
            testCnt, testFail, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the pooling testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module poolTb -f build.f
./obj_dir/VpoolTb | tee sim.log
if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
